// ==== Makefile ====
# Verilator build for the out-of-order back end testbench

VERILATOR  := verilator
TOP        := tb_ooo_core
FILELIST   := tb.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TESTS FAILED
PASS_MSG   := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu_unit.sv ====
// Single-cycle integer ALU holding its result until the commit grant
`timescale 1ns/1ps
`include "ooo_defines.svh"

module alu_unit
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_valid,
   input  ooo_pkg::fu_req_t            i_req,
   input  logic                        i_grant,
   output logic                        o_accept,
   output logic                        o_req,
   output logic [`OOO_ROB_DW-1:0]      o_id,
   output logic [`OOO_DW-1:0]          o_data,
   output logic [`OOO_TAG_W-1:0]       o_tag
);

   import ooo_pkg::*;

   localparam int MSB = `OOO_DW - 1;

   logic [`OOO_DW-1:0]   result;
   logic                 ovf;
   logic                 valid_q;

   always_comb
   begin
      ovf = 1'b0;
      case (i_req.op)
         OP_ADD:
         begin
            result = i_req.a + i_req.b;
            ovf = (i_req.a[MSB] == i_req.b[MSB]) && (result[MSB] != i_req.a[MSB]);
         end
         OP_SUB:
         begin
            result = i_req.a - i_req.b;
            ovf = (i_req.a[MSB] != i_req.b[MSB]) && (result[MSB] != i_req.a[MSB]);
         end
         OP_AND:  result = i_req.a & i_req.b;
         OP_OR:   result = i_req.a | i_req.b;
         OP_XOR:  result = i_req.a ^ i_req.b;
         default: result = '0;
      endcase
   end

   // Free when empty or when the held result leaves this cycle
   assign o_accept = !valid_q || i_grant;
   assign o_req = valid_q;

   always_ff @(posedge clk)
   begin
      if (i_reset)
         valid_q <= 1'b0;
      else if (i_valid)
         valid_q <= 1'b1;
      else if (i_grant)
         valid_q <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (i_valid)
      begin
         o_id <= i_req.id;
         o_data <= result;
         o_tag <= {1'b0, ovf};
      end
   end

endmodule

// ==== arch_regfile.sv ====
// Architectural register file written at retirement with register 0 reading zero
`timescale 1ns/1ps
`include "ooo_defines.svh"

module arch_regfile
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_we,
   input  logic [`OOO_REG_AW-1:0]      i_waddr,
   input  logic [`OOO_DW-1:0]          i_wdata,
   input  logic [`OOO_REG_AW-1:0]      i_raddr1,
   input  logic [`OOO_REG_AW-1:0]      i_raddr2,
   output logic [`OOO_DW-1:0]          o_rdata1,
   output logic [`OOO_DW-1:0]          o_rdata2
);

   localparam int NREG = 1 << `OOO_REG_AW;

   logic [`OOO_DW-1:0] regs_q [NREG];

   always_ff @(posedge clk)
   begin
      if (i_reset)
         regs_q <= '{default: '0};
      else if (i_we && (i_waddr != '0))
         regs_q[i_waddr] <= i_wdata;
   end

   assign o_rdata1 = regs_q[i_raddr1];
   assign o_rdata2 = regs_q[i_raddr2];

endmodule

// ==== commit_arbiter.sv ====
// Round-robin arbiter putting one unit result per cycle on the commit bus
`timescale 1ns/1ps
`include "ooo_defines.svh"

module commit_arbiter
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_alu_req,
   input  logic [`OOO_ROB_DW-1:0]      i_alu_id,
   input  logic [`OOO_DW-1:0]          i_alu_data,
   input  logic [`OOO_TAG_W-1:0]       i_alu_tag,
   input  logic                        i_mul_req,
   input  logic [`OOO_ROB_DW-1:0]      i_mul_id,
   input  logic [`OOO_DW-1:0]          i_mul_data,
   input  logic [`OOO_TAG_W-1:0]       i_mul_tag,
   output logic                        o_alu_grant,
   output logic                        o_mul_grant,
   commit_if.arb_src                   commit
);

   // Set when the multiplier won the last grant
   logic last_mul_q;

   assign o_alu_grant = i_alu_req && (!i_mul_req || last_mul_q);
   assign o_mul_grant = i_mul_req && (!i_alu_req || !last_mul_q);

   always_ff @(posedge clk)
   begin
      if (i_reset)
         last_mul_q <= 1'b0;
      else if (o_alu_grant || o_mul_grant)
         last_mul_q <= o_mul_grant;
   end

   assign commit.valid = o_alu_grant || o_mul_grant;
   assign commit.id = o_mul_grant ? i_mul_id : i_alu_id;
   assign commit.data = o_mul_grant ? i_mul_data : i_alu_data;
   assign commit.tag = o_mul_grant ? i_mul_tag : i_alu_tag;

   a_grant_mutex : assert property (@(posedge clk) disable iff (i_reset)
      !(o_alu_grant && o_mul_grant));

   // A unit that loses a tie holds its request and wins next time
   a_alu_no_starve : assert property (@(posedge clk) disable iff (i_reset)
      (i_alu_req && o_mul_grant) |=> o_alu_grant);
   a_mul_no_starve : assert property (@(posedge clk) disable iff (i_reset)
      (i_mul_req && o_alu_grant) |=> o_mul_grant);

endmodule

// ==== issue_unit.sv ====
// In-order issue stage that resolves operands and dispatches to one unit
`timescale 1ns/1ps
`include "ooo_defines.svh"

module issue_unit
(
   input  logic                        i_insn_valid,
   input  ooo_pkg::insn_u              i_insn,
   input  logic                        i_rob_ready,
   input  logic                        i_alu_accept,
   input  logic                        i_mul_accept,
   input  logic [`OOO_ROB_DW-1:0]      i_alloc_id,
   input  logic [`OOO_DW-1:0]          i_arf_rdata1,
   input  logic [`OOO_DW-1:0]          i_arf_rdata2,
   output logic                        o_insn_ready,
   output logic                        o_alloc,
   output logic                        o_alloc_rd_we,
   output logic [`OOO_REG_AW-1:0]      o_alloc_rd,
   output logic [`OOO_REG_AW-1:0]      o_arf_raddr1,
   output logic [`OOO_REG_AW-1:0]      o_arf_raddr2,
   output logic                        o_alu_valid,
   output logic                        o_mul_valid,
   output ooo_pkg::fu_req_t            o_fu_req,
   lookup_if.issue_side                lookup
);

   import ooo_pkg::*;

   logic                 is_imm;
   logic                 is_mul;
   opcode_e              base_op;
   logic [`OOO_DW-1:0]   imm_val;
   logic [`OOO_DW-1:0]   rs1_val;
   logic [`OOO_DW-1:0]   rs2_val;
   logic                 rs1_ok;
   logic                 rs2_ok;
   logic                 unit_ok;
   logic                 fire;

   // Form bit picks the union view
   assign is_imm = i_insn.reg_f.op[3];
   assign base_op = opcode_e'({1'b0, i_insn.reg_f.op[2:0]});
   assign is_mul = (base_op == OP_MUL);
   assign imm_val = {{(`OOO_DW-20){i_insn.imm_f.imm[19]}}, i_insn.imm_f.imm};

   assign lookup.rs1_addr = i_insn.reg_f.rs1;
   assign lookup.rs2_addr = i_insn.reg_f.rs2;
   assign o_arf_raddr1 = i_insn.reg_f.rs1;
   assign o_arf_raddr2 = i_insn.reg_f.rs2;

   assign rs1_val = lookup.rs1_from_rob ? lookup.rs1_data : i_arf_rdata1;
   assign rs2_val = lookup.rs2_from_rob ? lookup.rs2_data : i_arf_rdata2;

   // Stall while a producer is still in flight
   assign rs1_ok = lookup.rs1_from_rob || lookup.rs1_in_arf;
   assign rs2_ok = is_imm || lookup.rs2_from_rob || lookup.rs2_in_arf;
   assign unit_ok = is_mul ? i_mul_accept : i_alu_accept;

   assign o_insn_ready = rs1_ok && rs2_ok && i_rob_ready && unit_ok;
   assign fire = i_insn_valid && o_insn_ready;

   assign o_alloc = fire;
   assign o_alloc_rd = i_insn.reg_f.rd;
   assign o_alloc_rd_we = (i_insn.reg_f.rd != '0);
   assign o_alu_valid = fire && !is_mul;
   assign o_mul_valid = fire && is_mul;

   assign o_fu_req = '{op: base_op, a: rs1_val, b: (is_imm ? imm_val : rs2_val), id: i_alloc_id};

endmodule

// ==== mul_unit.sv ====
// Three-stage stallable signed multiplier keeping the low product word
`timescale 1ns/1ps
`include "ooo_defines.svh"

module mul_unit
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_valid,
   input  ooo_pkg::fu_req_t            i_req,
   input  logic                        i_grant,
   output logic                        o_accept,
   output logic                        o_req,
   output logic [`OOO_ROB_DW-1:0]      o_id,
   output logic [`OOO_DW-1:0]          o_data,
   output logic [`OOO_TAG_W-1:0]       o_tag
);

   localparam int DW = `OOO_DW;
   localparam int HW = DW / 2;

   logic                          v1_q;
   logic                          v2_q;
   logic                          v3_q;
   logic [`OOO_ROB_DW-1:0]        id1_q;
   logic [`OOO_ROB_DW-1:0]        id2_q;
   // Stage 1 splits b into a zero-extended low half and a signed high half
   logic signed [DW+HW:0]         plo_q;
   logic signed [DW+HW-1:0]       phi_q;
   logic signed [2*DW-1:0]        prod_sum;
   logic signed [2*DW-1:0]        prod_q;
   logic                          hi_flag_q;
   logic                          advance;

   // Whole pipe moves only when the last stage is free
   assign advance = !v3_q || i_grant;
   assign o_accept = advance;
   assign o_req = v3_q;

   assign prod_sum = (2*DW)'(plo_q) + ((2*DW)'(phi_q) <<< HW);

   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         v1_q <= 1'b0;
         v2_q <= 1'b0;
         v3_q <= 1'b0;
      end
      else if (advance)
      begin
         v1_q <= i_valid;
         v2_q <= v1_q;
         v3_q <= v2_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         id1_q <= i_req.id;
         plo_q <= $signed(i_req.a) * $signed({1'b0, i_req.b[HW-1:0]});
         phi_q <= $signed(i_req.a) * $signed(i_req.b[DW-1:HW]);
         id2_q <= id1_q;
         prod_q <= prod_sum;
         o_id <= id2_q;
         o_data <= prod_q[DW-1:0];
         // High word not a sign copy means the low word lost bits
         hi_flag_q <= (prod_q[2*DW-1:DW] != {DW{prod_q[DW-1]}});
      end
   end

   assign o_tag = {hi_flag_q, 1'b0};

endmodule

// ==== ooo_core.sv ====
// Out-of-order back end top level with issue, two units and reorder buffer
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_insn_valid,
   input  logic [31:0]                 i_insn,
   output logic                        o_insn_ready,
   output logic                        o_retire_valid,
   output logic                        o_retire_rd_we,
   output logic [`OOO_REG_AW-1:0]      o_retire_rd,
   output logic [`OOO_DW-1:0]          o_retire_data,
   output logic [`OOO_TAG_W-1:0]       o_retire_tag
);

   import ooo_pkg::*;

   logic                       alloc;
   logic                       alloc_rd_we;
   logic [`OOO_REG_AW-1:0]     alloc_rd;
   logic [`OOO_ROB_DW-1:0]     alloc_id;
   logic                       rob_ready;
   logic [`OOO_REG_AW-1:0]     arf_raddr1;
   logic [`OOO_REG_AW-1:0]     arf_raddr2;
   logic [`OOO_DW-1:0]         arf_rdata1;
   logic [`OOO_DW-1:0]         arf_rdata2;
   logic                       alu_valid;
   logic                       mul_valid;
   fu_req_t                    fu_req;
   logic                       alu_accept;
   logic                       alu_req;
   logic [`OOO_ROB_DW-1:0]     alu_id;
   logic [`OOO_DW-1:0]         alu_data;
   logic [`OOO_TAG_W-1:0]      alu_tag;
   logic                       alu_grant;
   logic                       mul_accept;
   logic                       mul_req;
   logic [`OOO_ROB_DW-1:0]     mul_id;
   logic [`OOO_DW-1:0]         mul_data;
   logic [`OOO_TAG_W-1:0]      mul_tag;
   logic                       mul_grant;

   commit_if commit_bus ();
   lookup_if lookup_bus ();

   issue_unit u_issue (
      .i_insn_valid (i_insn_valid), .i_insn (i_insn),
      .i_rob_ready (rob_ready), .i_alu_accept (alu_accept), .i_mul_accept (mul_accept),
      .i_alloc_id (alloc_id), .i_arf_rdata1 (arf_rdata1), .i_arf_rdata2 (arf_rdata2),
      .o_insn_ready (o_insn_ready), .o_alloc (alloc),
      .o_alloc_rd_we (alloc_rd_we), .o_alloc_rd (alloc_rd),
      .o_arf_raddr1 (arf_raddr1), .o_arf_raddr2 (arf_raddr2),
      .o_alu_valid (alu_valid), .o_mul_valid (mul_valid), .o_fu_req (fu_req),
      .lookup (lookup_bus.issue_side)
   );

   alu_unit u_alu (
      .clk (clk), .i_reset (i_reset), .i_valid (alu_valid), .i_req (fu_req),
      .i_grant (alu_grant), .o_accept (alu_accept), .o_req (alu_req),
      .o_id (alu_id), .o_data (alu_data), .o_tag (alu_tag)
   );

   mul_unit u_mul (
      .clk (clk), .i_reset (i_reset), .i_valid (mul_valid), .i_req (fu_req),
      .i_grant (mul_grant), .o_accept (mul_accept), .o_req (mul_req),
      .o_id (mul_id), .o_data (mul_data), .o_tag (mul_tag)
   );

   commit_arbiter u_arb (
      .clk (clk), .i_reset (i_reset),
      .i_alu_req (alu_req), .i_alu_id (alu_id), .i_alu_data (alu_data), .i_alu_tag (alu_tag),
      .i_mul_req (mul_req), .i_mul_id (mul_id), .i_mul_data (mul_data), .i_mul_tag (mul_tag),
      .o_alu_grant (alu_grant), .o_mul_grant (mul_grant),
      .commit (commit_bus.arb_src)
   );

   reorder_buffer u_rob (
      .clk (clk), .i_reset (i_reset),
      .i_alloc (alloc), .i_alloc_rd_we (alloc_rd_we), .i_alloc_rd (alloc_rd),
      .o_alloc_id (alloc_id), .o_rob_ready (rob_ready),
      .o_retire_valid (o_retire_valid), .o_retire_rd_we (o_retire_rd_we),
      .o_retire_rd (o_retire_rd), .o_retire_data (o_retire_data),
      .o_retire_tag (o_retire_tag),
      .lookup (lookup_bus.rob_side), .commit (commit_bus.rob_sink)
   );

   // Retirement is the only writer of architectural state
   arch_regfile u_arf (
      .clk (clk), .i_reset (i_reset),
      .i_we (o_retire_valid && o_retire_rd_we), .i_waddr (o_retire_rd),
      .i_wdata (o_retire_data),
      .i_raddr1 (arf_raddr1), .i_raddr2 (arf_raddr2),
      .o_rdata1 (arf_rdata1), .o_rdata2 (arf_rdata2)
   );

endmodule

// ==== ooo_defines.svh ====
// Width definitions shared by the out-of-order back end
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Data path width
`define OOO_DW 32
// Architectural register address width
`define OOO_REG_AW 4
// Reorder buffer index width for 8 entries
`define OOO_ROB_DW 3
// Result flag word width
`define OOO_TAG_W 2

`endif

// ==== ooo_if.sv ====
// Commit bus and operand lookup interfaces between back end blocks
`timescale 1ns/1ps
`include "ooo_defines.svh"

interface commit_if;
   logic                       valid;
   logic [`OOO_ROB_DW-1:0]     id;
   logic [`OOO_DW-1:0]         data;
   logic [`OOO_TAG_W-1:0]      tag;

   modport arb_src (output valid, id, data, tag);
   modport rob_sink (input valid, id, data, tag);
endinterface

interface lookup_if;
   logic [`OOO_REG_AW-1:0]     rs1_addr;
   logic [`OOO_REG_AW-1:0]     rs2_addr;
   logic                       rs1_from_rob;
   logic                       rs1_in_arf;
   logic [`OOO_DW-1:0]         rs1_data;
   logic                       rs2_from_rob;
   logic                       rs2_in_arf;
   logic [`OOO_DW-1:0]         rs2_data;

   // Answer comes back in the same cycle
   modport issue_side (
      output rs1_addr, rs2_addr,
      input  rs1_from_rob, rs1_in_arf, rs1_data, rs2_from_rob, rs2_in_arf, rs2_data
   );
   modport rob_side (
      input  rs1_addr, rs2_addr,
      output rs1_from_rob, rs1_in_arf, rs1_data, rs2_from_rob, rs2_in_arf, rs2_data
   );
endinterface

// ==== ooo_pkg.sv ====
// Instruction encoding and execution request types of the back end
`include "ooo_defines.svh"

package ooo_pkg;

   // Top bit selects the immediate form
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_MUL  = 4'h5,
      OP_ADDI = 4'h8,
      OP_SUBI = 4'h9,
      OP_ANDI = 4'hA,
      OP_ORI  = 4'hB,
      OP_XORI = 4'hC,
      OP_MULI = 4'hD
   } opcode_e;

   typedef struct packed {
      opcode_e                  op;
      logic [`OOO_REG_AW-1:0]   rd;
      logic [`OOO_REG_AW-1:0]   rs1;
      logic [`OOO_REG_AW-1:0]   rs2;
      logic [15:0]              unused;
   } insn_r_t;

   typedef struct packed {
      opcode_e                  op;
      logic [`OOO_REG_AW-1:0]   rd;
      logic [`OOO_REG_AW-1:0]   rs1;
      logic signed [19:0]       imm;
   } insn_i_t;

   typedef union packed {
      insn_r_t   reg_f;
      insn_i_t   imm_f;
   } insn_u;

   // Resolved operands with an op that has no form bit
   typedef struct packed {
      opcode_e                  op;
      logic [`OOO_DW-1:0]       a;
      logic [`OOO_DW-1:0]       b;
      logic [`OOO_ROB_DW-1:0]   id;
   } fu_req_t;

endpackage

// ==== reorder_buffer.sv ====
// Reorder buffer with operand lookup, commit bypass and in-order retirement
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reorder_buffer
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_alloc,
   input  logic                        i_alloc_rd_we,
   input  logic [`OOO_REG_AW-1:0]      i_alloc_rd,
   output logic [`OOO_ROB_DW-1:0]      o_alloc_id,
   output logic                        o_rob_ready,
   output logic                        o_retire_valid,
   output logic                        o_retire_rd_we,
   output logic [`OOO_REG_AW-1:0]      o_retire_rd,
   output logic [`OOO_DW-1:0]          o_retire_data,
   output logic [`OOO_TAG_W-1:0]       o_retire_tag,
   lookup_if.rob_side                  lookup,
   commit_if.rob_sink                  commit
);

   localparam int IW = `OOO_ROB_DW;
   localparam int DEPTH = 1 << IW;

   // Pointers carry a wrap bit above the index
   logic [IW:0]                w_ptr_q;
   logic [IW:0]                r_ptr_q;
   logic [IW-1:0]              r_idx;
   logic [DEPTH-1:0]           valid_q;
   logic [DEPTH-1:0]           ready_q;
   logic                       rd_we_q [DEPTH];
   logic [`OOO_REG_AW-1:0]     rd_q [DEPTH];
   logic [`OOO_DW-1:0]         data_q [DEPTH];
   logic [`OOO_TAG_W-1:0]      tag_q [DEPTH];
   logic                       full;

   // Index 0 of each pair is rs1 and index 1 is rs2
   logic [`OOO_REG_AW-1:0]     src_addr [2];
   logic [DEPTH-1:0]           hit [2];
   logic [DEPTH-1:0]           first [2];
   logic                       src_from_rob [2];
   logic                       src_in_arf [2];
   logic [`OOO_DW-1:0]         src_data [2];
   logic [IW-1:0]              age [DEPTH];

   assign r_idx = r_ptr_q[IW-1:0];
   assign full = (w_ptr_q[IW] != r_ptr_q[IW]) && (w_ptr_q[IW-1:0] == r_idx);
   assign o_rob_ready = !full;
   assign o_alloc_id = w_ptr_q[IW-1:0];

   // Head entry leaves once its result is in
   assign o_retire_valid = valid_q[r_idx] && ready_q[r_idx];
   assign o_retire_rd_we = rd_we_q[r_idx];
   assign o_retire_rd = rd_q[r_idx];
   assign o_retire_data = data_q[r_idx];
   assign o_retire_tag = tag_q[r_idx];

   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         valid_q <= '0;
         ready_q <= '0;
      end
      else
      begin
         if (i_alloc)
         begin
            valid_q[o_alloc_id] <= 1'b1;
            ready_q[o_alloc_id] <= 1'b0;
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (commit.valid)
            ready_q[commit.id] <= 1'b1;
         if (o_retire_valid)
         begin
            valid_q[r_idx] <= 1'b0;
            r_ptr_q <= r_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_alloc)
      begin
         rd_we_q[o_alloc_id] <= i_alloc_rd_we;
         rd_q[o_alloc_id] <= i_alloc_rd;
      end
      if (commit.valid)
      begin
         data_q[commit.id] <= commit.data;
         tag_q[commit.id] <= commit.tag;
      end
   end

   assign src_addr[0] = lookup.rs1_addr;
   assign src_addr[1] = lookup.rs2_addr;

   // Age counted back from the write pointer with the youngest entry at 0
   always_comb
   begin
      for (int e = 0; e < DEPTH; e++)
         age[e] = w_ptr_q[IW-1:0] - IW'(e) - 1'b1;
   end

   // A match counts only when no younger entry writes the same register
   always_comb
   begin
      for (int s = 0; s < 2; s++)
      begin
         for (int e = 0; e < DEPTH; e++)
            hit[s][e] = valid_q[e] && rd_we_q[e] && (rd_q[e] == src_addr[s]);
         for (int e = 0; e < DEPTH; e++)
         begin
            first[s][e] = hit[s][e];
            for (int j = 0; j < DEPTH; j++)
               if (hit[s][j] && (age[j] < age[e]))
                  first[s][e] = 1'b0;
         end
      end
   end

   always_comb
   begin
      for (int s = 0; s < 2; s++)
      begin
         src_from_rob[s] = 1'b0;
         src_data[s] = '0;
         for (int e = 0; e < DEPTH; e++)
         begin
            if (first[s][e] && ready_q[e])
            begin
               src_from_rob[s] = 1'b1;
               src_data[s] = data_q[e];
            end
            else if (first[s][e] && commit.valid && (commit.id == IW'(e)))
            begin
               // Result arriving on the commit bus this cycle
               src_from_rob[s] = 1'b1;
               src_data[s] = commit.data;
            end
         end
         src_in_arf[s] = (first[s] == '0);
      end
   end

   assign lookup.rs1_from_rob = src_from_rob[0];
   assign lookup.rs1_in_arf = src_in_arf[0];
   assign lookup.rs1_data = src_data[0];
   assign lookup.rs2_from_rob = src_from_rob[1];
   assign lookup.rs2_in_arf = src_in_arf[1];
   assign lookup.rs2_data = src_data[1];

   // Units only finish work that was dispatched and not yet finished
   a_commit_live : assert property (@(posedge clk) disable iff (i_reset)
      commit.valid |-> valid_q[commit.id] && !ready_q[commit.id]);

   a_first_onehot : assert property (@(posedge clk) disable iff (i_reset)
      $onehot0(first[0]) && $onehot0(first[1]));

endmodule

// ==== tb.f ====
+incdir+.
ooo_pkg.sv
ooo_if.sv
reorder_buffer.sv
arch_regfile.sv
issue_unit.sv
alu_unit.sv
mul_unit.sv
commit_arbiter.sv
ooo_core.sv
tb_ooo_core.sv

// ==== tb_ooo_core.sv ====
// Testbench driving a random stream into the back end and checking an in-order model
`timescale 1ns/1ps
`include "ooo_defines.svh"

module tb_ooo_core;

   import ooo_pkg::*;

   localparam int N_ALU = 60;
   localparam int N_DEP = 80;
   localparam int N_ZERO = 30;
   localparam int N_PRO = 6;
   localparam int N_FLAG = 50;
   localparam int N_FULL = 48;
   localparam int N_TOTAL = N_ALU + N_DEP + N_ZERO + N_PRO + N_FLAG + N_FULL;
   localparam int TIMEOUT_CYCLES = 40 * N_TOTAL;

   logic                       clk;
   logic                       i_reset;
   logic                       i_insn_valid;
   logic [31:0]                i_insn;
   logic                       o_insn_ready;
   logic                       o_retire_valid;
   logic                       o_retire_rd_we;
   logic [`OOO_REG_AW-1:0]     o_retire_rd;
   logic [`OOO_DW-1:0]         o_retire_data;
   logic [`OOO_TAG_W-1:0]      o_retire_tag;

   // Accepted but not yet retired in program order
   logic [31:0]   pending [$];
   logic [31:0]   model_regs [16];
   int            errors;
   int            accepted;
   int            retired;
   int            max_inflight;
   int            cycle_cnt;
   int            tests_run;
   int            tests_failed;
   bit            idle_en;

   ooo_core i_ooo_core (
      .clk (clk), .i_reset (i_reset), .i_insn_valid (i_insn_valid), .i_insn (i_insn),
      .o_insn_ready (o_insn_ready), .o_retire_valid (o_retire_valid),
      .o_retire_rd_we (o_retire_rd_we), .o_retire_rd (o_retire_rd),
      .o_retire_data (o_retire_data), .o_retire_tag (o_retire_tag)
   );

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Fail: %0s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Executes one instruction on the model registers
   task automatic model_exec(input logic [31:0] w, output logic we, output logic [3:0] rd,
                             output logic [31:0] data, output logic [1:0] tag);
      logic [2:0]    base;
      logic [31:0]   a;
      logic [31:0]   b;
      longint        sa;
      longint        sb;
      longint        wide;
      logic          lost;
      base = w[30:28];
      rd = w[27:24];
      a = model_regs[w[23:20]];
      b = w[31] ? {{12{w[19]}}, w[19:0]} : model_regs[w[19:16]];
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      case (base)
         3'd0: wide = sa + sb;
         3'd1: wide = sa - sb;
         3'd5: wide = sa * sb;
         default: wide = 0;
      endcase
      case (base)
         3'd2: data = a & b;
         3'd3: data = a | b;
         3'd4: data = a ^ b;
         default: data = wide[31:0];
      endcase
      // True result does not fit a signed 32-bit word
      lost = (wide != longint'($signed(wide[31:0])));
      tag = {(base == 3'd5) && lost, (base <= 3'd1) && lost};
      we = (rd != 4'd0);
      if (we)
         model_regs[rd] = data;
   endtask

   always @(posedge clk)
   begin : retire_monitor
      logic          exp_we;
      logic [3:0]    exp_rd;
      logic [31:0]   exp_data;
      logic [1:0]    exp_tag;
      if (!i_reset)
      begin
         if (o_retire_valid)
         begin
            retired++;
            assert (pending.size() != 0)
            else
            begin
               $display("Retirement seen with no instruction outstanding");
               errors++;
            end
            if (pending.size() != 0)
            begin
               model_exec(pending.pop_front(), exp_we, exp_rd, exp_data, exp_tag);
               check_value("o_retire_rd_we", 32'(o_retire_rd_we), 32'(exp_we));
               check_value("o_retire_rd", 32'(o_retire_rd), 32'(exp_rd));
               check_value("o_retire_data", o_retire_data, exp_data);
               check_value("o_retire_tag", 32'(o_retire_tag), 32'(exp_tag));
            end
         end
         if (i_insn_valid && o_insn_ready)
         begin
            pending.push_back(i_insn);
            accepted++;
         end
         assert (pending.size() <= 8)
         else
         begin
            $display("More than 8 instructions in flight: %0d", pending.size());
            errors++;
         end
         if (pending.size() > max_inflight)
            max_inflight = pending.size();
      end
   end

   function automatic logic [31:0] make_insn(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs1, input logic [3:0] rs2,
                                             input logic [19:0] imm);
      if (op[3])
         return {op, rd, rs1, imm};
      // Register form gets junk in the unused field
      return {op, rd, rs1, rs2, imm[15:0]};
   endfunction

   function automatic logic [3:0] rand_op(input bit with_mul);
      logic [2:0] base;
      base = 3'($urandom_range(with_mul ? 5 : 4));
      return {1'($urandom_range(1)), base};
   endfunction

   function automatic logic [2:0] pick_arith();
      case ($urandom_range(2))
         0: return 3'd0;
         1: return 3'd1;
         default: return 3'd5;
      endcase
   endfunction

   // Holds the word on the inputs until the DUT takes it
   task automatic send(input logic [31:0] w);
      @(negedge clk);
      if (idle_en && ($urandom_range(7) == 0))
      begin
         i_insn_valid = 1'b0;
         @(negedge clk);
      end
      i_insn_valid = 1'b1;
      i_insn = w;
      @(posedge clk);
      while (!o_insn_ready)
         @(posedge clk);
   endtask

   task automatic drain();
      @(negedge clk);
      i_insn_valid = 1'b0;
      while (pending.size() != 0)
         @(negedge clk);
   endtask

   task automatic report(input string name, input int start_err);
      tests_run++;
      if (errors != start_err)
         tests_failed++;
      $display("Test %0s finished with %0d errors", name, errors - start_err);
   endtask

   task automatic run_random(input string name, input int n, input bit with_mul,
                             input int lo, input int hi);
      int start_err;
      start_err = errors;
      for (int i = 0; i < n; i++)
         send(make_insn(rand_op(with_mul), 4'($urandom_range(hi, lo)),
                        4'($urandom_range(hi, lo)), 4'($urandom_range(hi, lo)), 20'($urandom)));
      drain();
      report(name, start_err);
   endtask

   task automatic run_zero(input int n);
      int start_err;
      start_err = errors;
      for (int i = 0; i < n; i++)
      begin
         if (i % 2 == 0)
            send(make_insn(rand_op(1'b1), 4'd0, 4'($urandom_range(2)),
                           4'($urandom_range(2)), 20'($urandom)));
         else
            send(make_insn(rand_op(1'b1), 4'($urandom_range(2, 1)), 4'd0,
                           4'($urandom_range(2)), 20'($urandom)));
      end
      drain();
      report("register_zero", start_err);
   endtask

   task automatic run_flags(input int n);
      int start_err;
      start_err = errors;
      // r8 to r11 end up near the signed limits
      send(make_insn(OP_ADDI, 4'd8, 4'd0, 4'd0, 20'd1));
      send(make_insn(OP_MULI, 4'd8, 4'd8, 4'd0, 20'h40000));
      send(make_insn(OP_MULI, 4'd8, 4'd8, 4'd0, 20'h02000));
      send(make_insn(OP_SUBI, 4'd9, 4'd8, 4'd0, 20'd1));
      send(make_insn(OP_ADDI, 4'd10, 4'd0, 4'd0, 20'hFFFFF));
      send(make_insn(OP_ADDI, 4'd11, 4'd8, 4'd0, 20'h01234));
      for (int i = 0; i < n; i++)
         send(make_insn({1'($urandom_range(1)), pick_arith()}, 4'($urandom_range(15, 12)),
                        4'($urandom_range(15, 8)), 4'($urandom_range(15, 8)), 20'($urandom)));
      drain();
      report("flag_tags", start_err);
   endtask

   // Independent MULs mixed with a few ALU ops and no idle cycles
   task automatic run_full(input int n);
      int            start_err;
      logic [3:0]    op;
      start_err = errors;
      idle_en = 1'b0;
      for (int i = 0; i < n; i++)
      begin
         op = (i % 4 == 3) ? {1'b0, 3'($urandom_range(4))} : 4'h5;
         send(make_insn(op, 4'($urandom_range(7, 1)), 4'($urandom_range(15, 8)),
                        4'($urandom_range(15, 8)), 20'($urandom)));
      end
      drain();
      idle_en = 1'b1;
      assert (retired == accepted)
      else
      begin
         $display("Retired count %0d does not match accepted count %0d", retired, accepted);
         errors++;
      end
      report("full_buffer", start_err);
   endtask

   initial
   begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles with %0d instructions outstanding",
               cycle_cnt, pending.size());
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      int start_err;
      void'($urandom(64));
      clk = 1'b0;
      i_reset = 1'b1;
      i_insn_valid = 1'b0;
      i_insn = '0;
      errors = 0;
      accepted = 0;
      retired = 0;
      max_inflight = 0;
      tests_run = 0;
      tests_failed = 0;
      idle_en = 1'b1;
      foreach (model_regs[r])
         model_regs[r] = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      i_reset = 1'b0;

      start_err = errors;
      check_value("o_retire_valid", 32'(o_retire_valid), 32'd0);
      check_value("o_insn_ready", 32'(o_insn_ready), 32'd1);
      report("reset_state", start_err);

      run_random("alu_in_order", N_ALU, 1'b0, 0, 3);
      run_random("raw_dependencies", N_DEP, 1'b1, 1, 3);
      run_zero(N_ZERO);
      run_flags(N_FLAG);
      run_full(N_FULL);

      $display("Summary: %0d tests, %0d failed, %0d errors, %0d retired, peak %0d in flight",
               tests_run, tests_failed, errors, retired, max_inflight);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule
